// File: verilog/dcache_pkg.sv
package dcache_pkg;

	// Address and word geometry
	localparam int ADDR_WIDTH   = 26;
	localparam int DATA_WIDTH   = 32;
	localparam int INDEX_WIDTH  = 6;
	localparam int OFFSET_WIDTH = 2;
	localparam int BYTE_WIDTH   = 2;
	localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - BYTE_WIDTH;

	// Cache organisation
	localparam int LINE_WORDS = 1 << OFFSET_WIDTH;
	localparam int DEPTH      = 1 << INDEX_WIDTH;
	localparam int WAYS       = 2;

	// Line mover FSM encoding
	localparam logic [2:0] ST_IDLE        = 3'd0;
	localparam logic [2:0] ST_FLUSH_REQ   = 3'd1;
	localparam logic [2:0] ST_FLUSH_DATA  = 3'd2;
	localparam logic [2:0] ST_REFILL_REQ  = 3'd3;
	localparam logic [2:0] ST_REFILL_DATA = 3'd4;

	// Byte address, seen as a raw word or split into cache fields
	typedef union packed {
		logic [ADDR_WIDTH-1:0] raw;
		struct packed {
			logic [TAG_WIDTH-1:0]    tag;
			logic [INDEX_WIDTH-1:0]  index;
			logic [OFFSET_WIDTH-1:0] offset;
			logic [BYTE_WIDTH-1:0]   byte_sel;
		} f;
	} dcache_addr_u;

endpackage

// File: verilog/cache_bank.sv
`timescale 1ns/1ps

module cache_bank #(
	parameter int DATA_BITS = dcache_pkg::DATA_WIDTH
) (
	input  logic                              clk,
	input  logic                              i_we,
	input  logic [dcache_pkg::INDEX_WIDTH-1:0] i_waddr,
	input  logic [dcache_pkg::INDEX_WIDTH-1:0] i_raddr,
	input  logic [DATA_BITS-1:0]              i_wdata,
	output logic [DATA_BITS-1:0]              o_rdata
);
	import dcache_pkg::*;

	logic [DATA_BITS-1:0] mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// Write-first port, a word written at this edge is read back at once
	always_ff @(posedge clk)
	begin
		if (i_we && i_waddr == i_raddr)
			o_rdata <= i_wdata;
		else
			o_rdata <= mem[i_raddr];
	end

endmodule

// File: verilog/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup (
	input  logic                                clk,
	input  logic                                rst_n,

	input  logic                                i_req_valid,
	input  logic                                i_req_write,
	input  dcache_pkg::dcache_addr_u            i_req_addr,

	input  logic [dcache_pkg::TAG_WIDTH-1:0]    i_tag0,
	input  logic [dcache_pkg::TAG_WIDTH-1:0]    i_tag1,

	input  logic                                i_busy,
	input  logic                                i_refill_done,
	input  logic                                i_fill_way,
	input  logic [dcache_pkg::INDEX_WIDTH-1:0]  i_fill_index,

	output logic                                o_hit,
	output logic                                o_miss,
	output logic                                o_way,
	output logic                                o_victim_dirty,
	output logic [dcache_pkg::TAG_WIDTH-1:0]    o_victim_tag
);
	import dcache_pkg::*;

	logic [DEPTH-1:0] valid_bits [WAYS];
	logic [DEPTH-1:0] dirty_bits [WAYS];
	// Per set, the way to evict next
	logic [DEPTH-1:0] lru_bits;

	logic [TAG_WIDTH-1:0]   req_tag;
	logic [INDEX_WIDTH-1:0] req_index;
	logic                   match0;
	logic                   match1;
	logic                   tag_hit;

	assign req_tag   = i_req_addr.f.tag;
	assign req_index = i_req_addr.f.index;

	always_comb
	begin
		match0  = valid_bits[0][req_index] && (i_tag0 == req_tag);
		match1  = valid_bits[1][req_index] && (i_tag1 == req_tag);
		tag_hit = match0 || match1;

		// No hits while a line is moving
		o_hit  = i_req_valid && !i_busy && tag_hit;
		o_miss = i_req_valid && !i_busy && !tag_hit;

		// Hit way on a match, LRU way otherwise
		if (tag_hit)
			o_way = match1;
		else
			o_way = lru_bits[req_index];

		o_victim_dirty = valid_bits[o_way][req_index] && dirty_bits[o_way][req_index];
		o_victim_tag   = o_way ? i_tag1 : i_tag0;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int w = 0; w < WAYS; w++)
			begin
				valid_bits[w] <= '0;
				dirty_bits[w] <= '0;
			end
			lru_bits <= '0;
		end
		else
		begin
			if (o_hit)
			begin
				lru_bits[req_index] <= !o_way;
				if (i_req_write)
					dirty_bits[o_way][req_index] <= 1'b1;
			end

			// Freshly filled line is clean
			if (i_refill_done)
			begin
				valid_bits[i_fill_way][i_fill_index] <= 1'b1;
				dirty_bits[i_fill_way][i_fill_index] <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/dcache_line_mover.sv
`timescale 1ns/1ps

module dcache_line_mover (
	input  logic                                   clk,
	input  logic                                   rst_n,

	// From the lookup
	input  logic                                   i_miss,
	input  logic                                   i_way,
	input  logic                                   i_victim_dirty,
	input  logic [dcache_pkg::TAG_WIDTH-1:0]       i_victim_tag,
	input  dcache_pkg::dcache_addr_u               i_req_addr,

	// Victim way line, read at the captured index
	input  logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::DATA_WIDTH-1:0] i_line_rdata,

	// Memory side inputs
	input  logic                                   i_mem_aw_ready,
	input  logic                                   i_mem_w_ready,
	input  logic                                   i_mem_ar_ready,
	input  logic                                   i_mem_r_valid,
	input  logic [dcache_pkg::DATA_WIDTH-1:0]      i_mem_r_data,

	// Back to the lookup and the banks
	output logic                                   o_busy,
	output logic                                   o_refill_done,
	output logic                                   o_fill_way,
	output logic [dcache_pkg::INDEX_WIDTH-1:0]     o_fill_index,
	output logic                                   o_read_index_hold,
	output logic [dcache_pkg::LINE_WORDS-1:0]      o_refill_we,
	output logic                                   o_tag_we,
	output logic [dcache_pkg::DATA_WIDTH-1:0]      o_refill_wdata,

	// Memory side outputs
	output logic                                   o_mem_aw_valid,
	output logic [dcache_pkg::ADDR_WIDTH-1:0]      o_mem_aw_addr,
	output logic                                   o_mem_w_valid,
	output logic [dcache_pkg::DATA_WIDTH-1:0]      o_mem_w_data,
	output logic                                   o_mem_w_last,
	output logic                                   o_mem_ar_valid,
	output logic [dcache_pkg::ADDR_WIDTH-1:0]      o_mem_ar_addr
);
	import dcache_pkg::*;

	logic [2:0] state;
	logic [2:0] next_state;

	// One-hot pointer to the word in flight
	logic [LINE_WORDS-1:0] word_sel;
	logic [LINE_WORDS-1:0][DATA_WIDTH-1:0] flush_data;

	// Miss context captured on the first miss cycle
	logic [TAG_WIDTH-1:0]   r_tag;
	logic [TAG_WIDTH-1:0]   r_victim_tag;
	logic [INDEX_WIDTH-1:0] r_index;
	logic                   r_way;

	logic         last_word;
	logic         w_fire;
	logic         r_fire;
	dcache_addr_u flush_addr;
	dcache_addr_u refill_addr;

	assign last_word = word_sel[LINE_WORDS-1];
	assign w_fire    = (state == ST_FLUSH_DATA) && i_mem_w_ready;
	assign r_fire    = (state == ST_REFILL_DATA) && i_mem_r_valid;

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:
				if (i_miss)
					next_state = i_victim_dirty ? ST_FLUSH_REQ : ST_REFILL_REQ;
			ST_FLUSH_REQ:
				if (i_mem_aw_ready)
					next_state = ST_FLUSH_DATA;
			ST_FLUSH_DATA:
				if (w_fire && last_word)
					next_state = ST_REFILL_REQ;
			ST_REFILL_REQ:
				if (i_mem_ar_ready)
					next_state = ST_REFILL_DATA;
			ST_REFILL_DATA:
				if (r_fire && last_word)
					next_state = ST_IDLE;
			default:
				next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= ST_IDLE;
			word_sel <= LINE_WORDS'(1);
		end
		else
		begin
			state <= next_state;
			if (w_fire || r_fire)
				word_sel <= {word_sel[LINE_WORDS-2:0], word_sel[LINE_WORDS-1]};
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && i_miss)
		begin
			r_tag        <= i_req_addr.f.tag;
			r_index      <= i_req_addr.f.index;
			r_way        <= i_way;
			r_victim_tag <= i_victim_tag;
		end
	end

	// Victim line is loaded once the burst address is taken, then shifted out
	always_ff @(posedge clk)
	begin
		if (state == ST_FLUSH_REQ && i_mem_aw_ready)
			flush_data <= i_line_rdata;
		else if (w_fire)
		begin
			for (int k = 0; k < LINE_WORDS - 1; k++)
				flush_data[k] <= flush_data[k+1];
		end
	end

	always_comb
	begin
		flush_addr.f.tag       = r_victim_tag;
		flush_addr.f.index     = r_index;
		flush_addr.f.offset    = '0;
		flush_addr.f.byte_sel  = '0;

		refill_addr.f.tag      = r_tag;
		refill_addr.f.index    = r_index;
		refill_addr.f.offset   = '0;
		refill_addr.f.byte_sel = '0;
	end

	assign o_mem_aw_valid = (state == ST_FLUSH_REQ);
	assign o_mem_aw_addr  = flush_addr.raw;
	assign o_mem_w_valid  = (state == ST_FLUSH_DATA);
	assign o_mem_w_data   = flush_data[0];
	assign o_mem_w_last   = o_mem_w_valid && last_word;
	assign o_mem_ar_valid = (state == ST_REFILL_REQ);
	assign o_mem_ar_addr  = refill_addr.raw;

	assign o_busy            = (state != ST_IDLE);
	assign o_read_index_hold = o_busy;
	assign o_refill_done     = r_fire && last_word;
	assign o_tag_we          = o_refill_done;
	assign o_refill_we       = r_fire ? word_sel : '0;
	assign o_refill_wdata    = i_mem_r_data;
	assign o_fill_way        = r_way;
	assign o_fill_index      = r_index;

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
	input  logic                              clk,
	input  logic                              rst_n,

	// Requester
	input  logic                              i_req_valid,
	input  logic                              i_req_write,
	input  logic [dcache_pkg::ADDR_WIDTH-1:0] i_req_addr,
	input  logic [dcache_pkg::DATA_WIDTH-1:0] i_req_wdata,
	input  logic [dcache_pkg::ADDR_WIDTH-1:0] i_req_addr_next,
	output logic                              o_resp_valid,
	output logic [dcache_pkg::DATA_WIDTH-1:0] o_resp_rdata,

	// Memory channels
	output logic                              o_mem_aw_valid,
	output logic [dcache_pkg::ADDR_WIDTH-1:0] o_mem_aw_addr,
	input  logic                              i_mem_aw_ready,
	output logic                              o_mem_w_valid,
	output logic [dcache_pkg::DATA_WIDTH-1:0] o_mem_w_data,
	output logic                              o_mem_w_last,
	input  logic                              i_mem_w_ready,
	output logic                              o_mem_ar_valid,
	output logic [dcache_pkg::ADDR_WIDTH-1:0] o_mem_ar_addr,
	input  logic                              i_mem_ar_ready,
	input  logic                              i_mem_r_valid,
	input  logic [dcache_pkg::DATA_WIDTH-1:0] i_mem_r_data
);
	import dcache_pkg::*;

	dcache_addr_u req_addr;
	dcache_addr_u req_addr_next;

	logic [INDEX_WIDTH-1:0] rd_index;
	logic [INDEX_WIDTH-1:0] wr_index;
	logic [TAG_WIDTH-1:0]   tag0_rdata;
	logic [TAG_WIDTH-1:0]   tag1_rdata;
	logic [DATA_WIDTH-1:0]  data_wdata;
	logic [WAYS-1:0][LINE_WORDS-1:0]                 data_we;
	logic [WAYS-1:0][LINE_WORDS-1:0][DATA_WIDTH-1:0] data_rdata;

	logic                   hit;
	logic                   miss;
	logic                   way;
	logic                   victim_dirty;
	logic [TAG_WIDTH-1:0]   victim_tag;
	logic                   busy;
	logic                   refill_done;
	logic                   fill_way;
	logic [INDEX_WIDTH-1:0] fill_index;
	logic                   read_index_hold;
	logic [LINE_WORDS-1:0]  refill_we;
	logic                   tag_we;
	logic [DATA_WIDTH-1:0]  refill_wdata;

	assign req_addr      = i_req_addr;
	assign req_addr_next = i_req_addr_next;

	// Banks read one cycle ahead, except while a line is moving
	assign rd_index = read_index_hold ? fill_index : req_addr_next.f.index;

	// Refill words during a miss, the store word on a write hit
	assign wr_index   = busy ? fill_index : req_addr.f.index;
	assign data_wdata = busy ? refill_wdata : i_req_wdata;

	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
		begin
			for (int k = 0; k < LINE_WORDS; k++)
			begin
				data_we[w][k] = (refill_we[k] && fill_way == 1'(w))
					|| (hit && i_req_write && way == 1'(w)
						&& req_addr.f.offset == OFFSET_WIDTH'(k));
			end
		end
	end

	cache_bank #(.DATA_BITS(TAG_WIDTH)) tag0 (
		.clk     (clk),
		.i_we    (tag_we && !fill_way),
		.i_waddr (fill_index),
		.i_raddr (rd_index),
		.i_wdata (req_addr.f.tag),
		.o_rdata (tag0_rdata)
	);

	cache_bank #(.DATA_BITS(TAG_WIDTH)) tag1 (
		.clk     (clk),
		.i_we    (tag_we && fill_way),
		.i_waddr (fill_index),
		.i_raddr (rd_index),
		.i_wdata (req_addr.f.tag),
		.o_rdata (tag1_rdata)
	);

	for (genvar w = 0; w < WAYS; w++)
	begin : gen_way
		for (genvar k = 0; k < LINE_WORDS; k++)
		begin : gen_word
			cache_bank #(.DATA_BITS(DATA_WIDTH)) data_bank (
				.clk     (clk),
				.i_we    (data_we[w][k]),
				.i_waddr (wr_index),
				.i_raddr (rd_index),
				.i_wdata (data_wdata),
				.o_rdata (data_rdata[w][k])
			);
		end
	end

	dcache_lookup lookup0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_req_valid    (i_req_valid),
		.i_req_write    (i_req_write),
		.i_req_addr     (req_addr),
		.i_tag0         (tag0_rdata),
		.i_tag1         (tag1_rdata),
		.i_busy         (busy),
		.i_refill_done  (refill_done),
		.i_fill_way     (fill_way),
		.i_fill_index   (fill_index),
		.o_hit          (hit),
		.o_miss         (miss),
		.o_way          (way),
		.o_victim_dirty (victim_dirty),
		.o_victim_tag   (victim_tag)
	);

	dcache_line_mover mover0 (
		.clk               (clk),
		.rst_n             (rst_n),
		.i_miss            (miss),
		.i_way             (way),
		.i_victim_dirty    (victim_dirty),
		.i_victim_tag      (victim_tag),
		.i_req_addr        (req_addr),
		.i_line_rdata      (data_rdata[fill_way]),
		.i_mem_aw_ready    (i_mem_aw_ready),
		.i_mem_w_ready     (i_mem_w_ready),
		.i_mem_ar_ready    (i_mem_ar_ready),
		.i_mem_r_valid     (i_mem_r_valid),
		.i_mem_r_data      (i_mem_r_data),
		.o_busy            (busy),
		.o_refill_done     (refill_done),
		.o_fill_way        (fill_way),
		.o_fill_index      (fill_index),
		.o_read_index_hold (read_index_hold),
		.o_refill_we       (refill_we),
		.o_tag_we          (tag_we),
		.o_refill_wdata    (refill_wdata),
		.o_mem_aw_valid    (o_mem_aw_valid),
		.o_mem_aw_addr     (o_mem_aw_addr),
		.o_mem_w_valid     (o_mem_w_valid),
		.o_mem_w_data      (o_mem_w_data),
		.o_mem_w_last      (o_mem_w_last),
		.o_mem_ar_valid    (o_mem_ar_valid),
		.o_mem_ar_addr     (o_mem_ar_addr)
	);

	// Load data from the hit way at the request offset
	assign o_resp_valid = hit;
	assign o_resp_rdata = data_rdata[way][req_addr.f.offset];

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk,
	output logic o_rst_n
);

	initial
	begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// Reset held low for eight rising edges
	initial
	begin
		o_rst_n = 1'b0;
		repeat (8) @(posedge o_clk);
		#1 o_rst_n = 1'b1;
	end

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_aw_valid,
	input  logic [25:0] i_aw_addr,
	output logic        o_aw_ready,
	input  logic        i_w_valid,
	input  logic [31:0] i_w_data,
	input  logic        i_w_last,
	output logic        o_w_ready,
	input  logic        i_ar_valid,
	input  logic [25:0] i_ar_addr,
	output logic        o_ar_ready,
	output logic        o_r_valid,
	output logic [31:0] o_r_data
);

	integer seed;
	logic [31:0] mem [1024];

	// Burst records, read by the top testbench
	int          read_count;
	logic [25:0] read_addr;
	int          rd_left;
	int          rd_pos;
	int          flush_count;
	int          flush_beats;
	logic [25:0] flush_addr;
	logic [31:0] flush_words [4];
	logic [3:0]  flush_last;

	initial
	begin
		seed = 69;
		for (int i = 0; i < 1024; i++)
			mem[i] = (i * 32'h9e3779b1) ^ 32'hc3a5_0f1e;
		read_count = 0;
		rd_left = 0;
		rd_pos = 0;
		flush_count = 0;
		flush_beats = 0;
		flush_last = '0;
		o_aw_ready = 1'b0;
		o_w_ready = 1'b0;
		o_ar_ready = 1'b0;
		o_r_valid = 1'b0;
		o_r_data = '0;
	end

	// Signals are stable from 1 ns after the edge, so the negedge sees what the next edge takes
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (i_aw_valid && o_aw_ready)
			begin
				flush_addr = i_aw_addr;
				flush_beats = 0;
				flush_last = '0;
				flush_count++;
			end
			if (i_w_valid && o_w_ready && flush_beats < 4)
			begin
				mem[int'(flush_addr[11:2]) + flush_beats] = i_w_data;
				flush_words[flush_beats] = i_w_data;
				flush_last[flush_beats] = i_w_last;
				flush_beats++;
			end
			if (i_ar_valid && o_ar_ready)
			begin
				read_addr = i_ar_addr;
				read_count++;
				rd_left = 4;
				rd_pos = 0;
			end
			if (o_r_valid)
			begin
				rd_left--;
				rd_pos++;
			end
		end
	end

	always @(posedge clk)
	begin
		#1;
		o_aw_ready = rst_n && $random(seed) % 2 != 0;
		o_w_ready = rst_n && $random(seed) % 2 != 0;
		o_ar_ready = rst_n && $random(seed) % 2 != 0;
		o_r_valid = rst_n && rd_left > 0 && ($random(seed) & 3) != 0;
		o_r_data = o_r_valid ? mem[int'(read_addr[11:2]) + rd_pos] : '0;
	end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

	localparam int N_REQ = 600;

	logic        clk;
	logic        rst_n;
	logic        i_req_valid;
	logic        i_req_write;
	logic [25:0] i_req_addr;
	logic [31:0] i_req_wdata;
	logic [25:0] i_req_addr_next;
	logic        o_resp_valid;
	logic [31:0] o_resp_rdata;
	logic        aw_valid, aw_ready, w_valid, w_last, w_ready;
	logic        ar_valid, ar_ready, r_valid;
	logic [25:0] aw_addr, ar_addr;
	logic [31:0] w_data, r_data;

	integer seed;
	logic [31:0] ref_mem [1024];
	// Per set, slot 0 is the most recently used tag
	int set_cnt [3];
	int set_tag [3][2];
	bit set_dirty [3][2];

	logic [25:0] cur_addr, nxt_addr;
	logic        cur_write, nxt_write;
	logic [31:0] cur_wdata, nxt_wdata;
	int          cur_tag, cur_set, nxt_tag, nxt_set;

	tb_clock clk0 (.o_clk(clk), .o_rst_n(rst_n));

	tb_mem_model mem0 (
		.clk(clk), .rst_n(rst_n),
		.i_aw_valid(aw_valid), .i_aw_addr(aw_addr), .o_aw_ready(aw_ready),
		.i_w_valid(w_valid), .i_w_data(w_data), .i_w_last(w_last), .o_w_ready(w_ready),
		.i_ar_valid(ar_valid), .i_ar_addr(ar_addr), .o_ar_ready(ar_ready),
		.o_r_valid(r_valid), .o_r_data(r_data)
	);

	dcache_top dut0 (
		.clk(clk), .rst_n(rst_n),
		.i_req_valid(i_req_valid), .i_req_write(i_req_write), .i_req_addr(i_req_addr),
		.i_req_wdata(i_req_wdata), .i_req_addr_next(i_req_addr_next),
		.o_resp_valid(o_resp_valid), .o_resp_rdata(o_resp_rdata),
		.o_mem_aw_valid(aw_valid), .o_mem_aw_addr(aw_addr), .i_mem_aw_ready(aw_ready),
		.o_mem_w_valid(w_valid), .o_mem_w_data(w_data), .o_mem_w_last(w_last),
		.i_mem_w_ready(w_ready),
		.o_mem_ar_valid(ar_valid), .o_mem_ar_addr(ar_addr), .i_mem_ar_ready(ar_ready),
		.i_mem_r_valid(r_valid), .i_mem_r_data(r_data)
	);

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timed out at %0t ns waiting for %s", $time, what);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// Tag in bits 25:10, index in 9:4, word offset in 3:2
	function automatic logic [25:0] line_addr(input int tag, input int set);
		int idx;
		idx = (set == 0) ? 0 : (set == 1) ? 17 : 63;
		return 26'((tag << 10) | (idx << 4));
	endfunction

	task automatic pick_request();
		logic [31:0] r;
		r = $random(seed);
		nxt_tag = int'(r[1:0]);
		nxt_set = int'(r[5:2]) % 3;
		nxt_addr = line_addr(nxt_tag, nxt_set) | 26'({r[7:6], 2'b00});
		nxt_write = r[8];
		nxt_wdata = $random(seed);
	endtask

	initial
	begin
		int waits;
		int rc0;
		int fc0;
		bit exp_hit;
		bit exp_flush;
		bit hit_dirty;
		int vtag;
		int s;
		logic [25:0] vline;

		seed = 69;
		i_req_valid = 1'b0;
		i_req_write = 1'b0;
		i_req_addr = '0;
		i_req_wdata = '0;
		i_req_addr_next = '0;
		for (int k = 0; k < 3; k++)
			set_cnt[k] = 0;

		waits = 0;
		while (rst_n !== 1'b1)
		begin
			@(posedge clk);
			waits++;
			if (waits > 50)
				fail_timeout("reset release");
		end
		for (int i = 0; i < 1024; i++)
			ref_mem[i] = mem0.mem[i];

		// Nothing may move while idle after reset
		pick_request();
		repeat (4)
		begin
			@(posedge clk);
			#1 i_req_addr_next = nxt_addr;
			@(negedge clk);
			check_value(32'(o_resp_valid), 0, "response valid while idle");
			check_value(32'({aw_valid, w_valid, ar_valid}), 0, "memory valid while idle");
		end

		for (int n = 0; n < N_REQ; n++)
		begin
			@(posedge clk);
			#1;
			cur_addr = nxt_addr;
			cur_write = nxt_write;
			cur_wdata = nxt_wdata;
			cur_tag = nxt_tag;
			cur_set = nxt_set;
			pick_request();
			s = cur_set;
			exp_hit = (set_cnt[s] > 0 && set_tag[s][0] == cur_tag)
				|| (set_cnt[s] > 1 && set_tag[s][1] == cur_tag);
			exp_flush = !exp_hit && set_cnt[s] == 2 && set_dirty[s][1];
			vtag = set_tag[s][1];
			i_req_valid = 1'b1;
			i_req_write = cur_write;
			i_req_addr = cur_addr;
			i_req_wdata = cur_wdata;
			i_req_addr_next = exp_hit ? nxt_addr : cur_addr;
			rc0 = mem0.read_count;
			fc0 = mem0.flush_count;

			@(negedge clk);
			check_value(32'(o_resp_valid), 32'(exp_hit), "hit on first request cycle");
			waits = 0;
			while (!o_resp_valid)
			begin
				@(posedge clk);
				#1;
				// The hit follows the last refill word
				if (mem0.read_count != rc0 && mem0.rd_left == 0)
					i_req_addr_next = nxt_addr;
				@(negedge clk);
				waits++;
				if (waits > 300)
					fail_timeout("response after a miss");
			end

			if (!cur_write)
				check_value(o_resp_rdata, ref_mem[cur_addr[11:2]], "load data");
			check_value(mem0.read_count, rc0 + (exp_hit ? 0 : 1), "refill burst count");
			if (!exp_hit)
				check_value(32'(mem0.read_addr), 32'(line_addr(cur_tag, s)), "refill address");
			check_value(mem0.flush_count, fc0 + (exp_flush ? 1 : 0), "flush burst count");
			if (exp_flush)
			begin
				vline = line_addr(vtag, s);
				check_value(32'(mem0.flush_addr), 32'(vline), "flush address");
				check_value(32'(mem0.flush_last), 32'h8, "flush last flags");
				for (int k = 0; k < 4; k++)
					check_value(mem0.flush_words[k], ref_mem[int'(vline[11:2]) + k],
						"flush data");
			end

			// Update the reference model
			if (cur_write)
				ref_mem[cur_addr[11:2]] = cur_wdata;
			if (exp_hit && set_tag[s][0] != cur_tag)
			begin
				hit_dirty = set_dirty[s][1];
				set_tag[s][1] = set_tag[s][0];
				set_dirty[s][1] = set_dirty[s][0];
				set_tag[s][0] = cur_tag;
				set_dirty[s][0] = hit_dirty | cur_write;
			end
			else if (exp_hit)
				set_dirty[s][0] = set_dirty[s][0] | cur_write;
			else
			begin
				set_tag[s][1] = set_tag[s][0];
				set_dirty[s][1] = set_dirty[s][0];
				set_tag[s][0] = cur_tag;
				set_dirty[s][0] = cur_write;
				if (set_cnt[s] < 2)
					set_cnt[s]++;
			end
		end

		@(posedge clk);
		#1 i_req_valid = 1'b0;
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: tb.f
verilog/dcache_pkg.sv
verilog/cache_bank.sv
verilog/dcache_lookup.sv
verilog/dcache_line_mover.sv
verilog/dcache_top.sv
tests/tb_clock.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

// File: Makefile
TOP := tb_dcache

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP)
	-./obj_dir/V$(TOP) | tee sim.log
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
